// File: flTicketSplitter.f
+incdir+verification
hdl/flTicketPkg.sv
hdl/ticketFifo.sv
hdl/frameRouter.sv
hdl/flOutPort.sv
hdl/flTicketSplitter.sv
verification/flTicketSplitterTb.sv

// File: Bender.yml
package:
  name: fl_ticket_splitter

sources:
  - files:
      - hdl/flTicketPkg.sv
      - hdl/ticketFifo.sv
      - hdl/frameRouter.sv
      - hdl/flOutPort.sv
      - hdl/flTicketSplitter.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/flTicketSplitterTb.sv

// File: verification/splitterModel.svh
// expected-result queues and reference model; laneCount and maxWords must be declared before the include
`ifndef SPLITTER_MODEL_SVH
`define SPLITTER_MODEL_SVH

localparam int wordBits = dataWidth + dremWidth + 2;  // packed as data, drem, sof, eof

logic [wordBits-1:0] expWords [laneCount][$];  // words each TX port still owes
ticketT              expTags  [laneCount][$];  // tickets whose tag each ctrlOut still owes

// every lane whose mask bit is set gets the whole frame and then one tag, in frame order
function automatic void modelFrame(input ticketT ticket,
                                   input logic [dataWidth-1:0] words [maxWords],
                                   input int len, input logic [dremWidth-1:0] lastDrem);
  logic [dremWidth-1:0] drem;
  logic                 first;
  logic                 last;
  for (int lane = 0; lane < laneCount; lane++) begin
    if (ticket.fields.mask[lane]) begin  // a zero mask leaves every queue untouched
      for (int w = 0; w < len; w++) begin
        first = (w == 0);
        last  = (w == len - 1);
        drem  = last ? lastDrem : '0;  // stimulus drives drem only on eof
        expWords[lane].push_back({words[w], drem, first, last});
      end
      expTags[lane].push_back(ticket);  // mask is stripped on the way out, only the tag counts
    end
  end
endfunction

// true once no lane owes a word or a tag
function automatic bit queuesEmpty();
  bit empty;
  empty = 1'b1;
  for (int lane = 0; lane < laneCount; lane++) begin
    if (expWords[lane].size() != 0 || expTags[lane].size() != 0) begin
      empty = 1'b0;
    end
  end
  return empty;
endfunction

`endif

// File: verification/flTicketSplitterTb.sv
// four-lane run of 200 random frames and tickets under random back-pressure; stops at the first error
`timescale 1ns/1ps

module flTicketSplitterTb import flTicketPkg::*; ();

  localparam int laneCount     = 4;
  localparam int frameCount    = 200;
  localparam int maxWords      = 8;
  localparam int period        = 40;
  localparam int driveDelay    = 2;      // inputs change this long after the rising edge
  localparam int resetCycles   = 4;
  localparam int timeoutCycles = 20000;  // 200 frames of up to 8 words four times over with margin

  logic                                clk;
  logic                                rstN;
  logic [dataWidth-1:0]                rxData;
  logic [dremWidth-1:0]                rxDrem;
  logic                                rxSof;
  logic                                rxEof;
  logic                                rxSrcRdy;
  logic                                rxDstRdy;
  logic [ticketWidth-1:0]              ctrlInTicket;
  logic                                ctrlInSrcRdy;
  logic                                ctrlInDstRdy;
  logic [laneCount-1:0][dataWidth-1:0] txData;
  logic [laneCount-1:0][dremWidth-1:0] txDrem;
  logic [laneCount-1:0]                txSof;
  logic [laneCount-1:0]                txEof;
  logic [laneCount-1:0]                txSrcRdy;
  logic [laneCount-1:0]                txDstRdy;
  logic [laneCount-1:0][tagWidth-1:0]  ctrlOutTag;
  logic [laneCount-1:0]                ctrlOutSrcRdy;
  logic [laneCount-1:0]                ctrlOutDstRdy;

  integer               seed = 32'h53c;
  int                   cycles = 0;
  ticketT               tickets    [frameCount];            // one ticket per frame in frame order
  logic [dataWidth-1:0] frameWords [frameCount][maxWords];
  int                   frameLen   [frameCount];
  logic [dremWidth-1:0] frameDrem  [frameCount];            // drem of the eof word

  `include "splitterModel.svh"

  flTicketSplitter #(.outputCount(laneCount)) flTicketSplitter_i (.*);

  task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic checkLow(input logic [laneCount-1:0] got, input string what);
    if (got !== '0) stopOnFailure($sformatf("CHECK FAILED at %0t: %s is %b during reset",
                                            $time, what, got));
  endtask

  task automatic checkWord(input int lane, input logic [dataWidth-1:0] expData,
                           input logic [dremWidth-1:0] expDrem, input logic expSof,
                           input logic expEof);
    if (txData[lane] !== expData || txDrem[lane] !== expDrem || txSof[lane] !== expSof ||
        txEof[lane] !== expEof) begin
      stopOnFailure($sformatf(
        "CHECK FAILED at %0t: lane %0d word %h/%0d/%b/%b, expected %h/%0d/%b/%b",
        $time, lane, txData[lane], txDrem[lane], txSof[lane], txEof[lane],
        expData, expDrem, expSof, expEof));
    end
  endtask

  task automatic checkTag(input int lane, input ticketT expTicket);
    if (ctrlOutTag[lane] !== expTicket.fields.tag) begin
      stopOnFailure($sformatf("CHECK FAILED at %0t: lane %0d tag %h, expected %h",
                              $time, lane, ctrlOutTag[lane], expTicket.fields.tag));
    end
  endtask

  task automatic sendTickets();
    for (int t = 0; t < frameCount; t++) begin
      ctrlInTicket = tickets[t].raw;
      ctrlInSrcRdy = 1'b1;
      do @(negedge clk); while (!ctrlInDstRdy);  // handshake is settled by the falling edge
      @(posedge clk);
      #driveDelay;
    end
    ctrlInSrcRdy = 1'b0;
  endtask

  task automatic sendFrames();
    logic [dataWidth-1:0] words [maxWords];
    repeat (12) @(posedge clk);  // tickets pile up in the FIFO before the first frame
    #driveDelay;
    for (int f = 0; f < frameCount; f++) begin
      for (int w = 0; w < maxWords; w++) words[w] = frameWords[f][w];
      modelFrame(tickets[f], words, frameLen[f], frameDrem[f]);
      for (int w = 0; w < frameLen[f]; w++) begin
        rxData   = frameWords[f][w];
        rxSof    = (w == 0);
        rxEof    = (w == frameLen[f] - 1);
        rxDrem   = rxEof ? frameDrem[f] : '0;
        rxSrcRdy = 1'b1;
        do @(negedge clk); while (!rxDstRdy);
        @(posedge clk);
        #driveDelay;
      end
    end
    rxSrcRdy = 1'b0;
    rxSof    = 1'b0;
    rxEof    = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == timeoutCycles) begin
      stopOnFailure("the run timed out before every expected word and tag was delivered");
    end
  end

  // random ready on each TX and ctrlOut lane drawn once per cycle after reset
  initial begin : backPressure
    logic [31:0] rnd;
    txDstRdy      = '0;
    ctrlOutDstRdy = '0;
    @(posedge rstN);
    forever begin
      @(posedge clk);
      #driveDelay;
      rnd           = $random(seed);
      txDstRdy      = rnd[laneCount-1:0];
      ctrlOutDstRdy = rnd[2*laneCount-1:laneCount];
    end
  end

  // a transfer seen at the falling edge completes on the next rising edge
  always @(negedge clk) begin : compareOutputs
    logic [wordBits-1:0] expWord;
    if (rstN) begin
      for (int lane = 0; lane < laneCount; lane++) begin
        if (txSrcRdy[lane] && txDstRdy[lane]) begin
          if (expWords[lane].size() == 0) begin
            stopOnFailure($sformatf("lane %0d sent a word that no ticket routed to it", lane));
          end else begin
            expWord = expWords[lane].pop_front();
            checkWord(lane, expWord[wordBits-1 -: dataWidth], expWord[dremWidth+1:2],
                      expWord[1], expWord[0]);
          end
        end
        if (ctrlOutSrcRdy[lane] && ctrlOutDstRdy[lane]) begin
          if (expTags[lane].size() == 0) begin
            stopOnFailure($sformatf("lane %0d sent a tag that no ticket routed to it", lane));
          end else begin
            checkTag(lane, expTags[lane].pop_front());
          end
        end
      end
    end
  end

  initial begin : mainFlow
    logic [31:0] rnd;
    rstN         = 1'b0;
    rxData       = '0;
    rxDrem       = '0;
    rxSof        = 1'b0;
    rxEof        = 1'b0;
    rxSrcRdy     = 1'b0;
    ctrlInTicket = '0;
    ctrlInSrcRdy = 1'b0;
    for (int f = 0; f < frameCount; f++) begin
      rnd             = $random(seed);
      frameLen[f]     = int'(rnd[2:0]) + 1;
      frameDrem[f]    = rnd[4:3];
      rnd             = $random(seed);
      tickets[f].raw  = rnd[ticketWidth-1:0];
      if (f % 25 == 7) tickets[f].fields.mask = '0;  // some frames must vanish
      for (int w = 0; w < maxWords; w++) frameWords[f][w] = $random(seed);
    end
    repeat (resetCycles) begin
      @(negedge clk);
      checkLow(laneCount'(rxDstRdy), "rxDstRdy");
      checkLow(laneCount'(ctrlInDstRdy), "ctrlInDstRdy");
      checkLow(txSrcRdy, "txSrcRdy");
      checkLow(ctrlOutSrcRdy, "ctrlOutSrcRdy");
    end
    @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    fork
      sendTickets();
      sendFrames();
    join
    while (!queuesEmpty()) @(negedge clk);
    repeat (16) @(negedge clk);  // a stray transfer in this window is caught by the compare process
    if (txSrcRdy === '0 && ctrlOutSrcRdy === '0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stopOnFailure("a lane still held a word or tag that no ticket routed to it");
    end
  end

endmodule : flTicketSplitterTb

// File: hdl/flTicketSplitter.sv
// ticket splitter top; outputCount from 1 to maxOutputs, each frame needs exactly one ticket
`timescale 1ns/1ps

module flTicketSplitter import flTicketPkg::*; #(
  parameter int outputCount = 4  // number of TX and ctrlOut lanes
) (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic [dataWidth-1:0]                 rxData,
  input  logic [dremWidth-1:0]                 rxDrem,
  input  logic                                 rxSof,
  input  logic                                 rxEof,
  input  logic                                 rxSrcRdy,
  output logic                                 rxDstRdy,
  input  logic [ticketWidth-1:0]               ctrlInTicket,
  input  logic                                 ctrlInSrcRdy,
  output logic                                 ctrlInDstRdy,
  output logic [outputCount-1:0][dataWidth-1:0] txData,
  output logic [outputCount-1:0][dremWidth-1:0] txDrem,
  output logic [outputCount-1:0]               txSof,
  output logic [outputCount-1:0]               txEof,
  output logic [outputCount-1:0]               txSrcRdy,
  input  logic [outputCount-1:0]               txDstRdy,
  output logic [outputCount-1:0][tagWidth-1:0] ctrlOutTag,
  output logic [outputCount-1:0]               ctrlOutSrcRdy,
  input  logic [outputCount-1:0]               ctrlOutDstRdy
);

  localparam int ticketDepth = 4;  // tickets that may arrive ahead of their frames

  ticketT                 headTicket;    // oldest ticket, owns the frame on RX
  logic                   headValid;
  logic                   pop;           // eof accepted, ticket done
  logic [dataWidth-1:0]   laneData;      // word bus shared by all lanes
  logic [dremWidth-1:0]   laneDrem;
  logic                   laneSof;
  logic                   laneEof;
  logic [outputCount-1:0] laneWrite;
  logic [outputCount-1:0] laneTagWrite;
  logic [tagWidth-1:0]    laneTag;
  logic [outputCount-1:0] laneFree;
  logic [outputCount-1:0] laneTagFree;

  ticketFifo #(
    .depth(ticketDepth)
  ) ticketFifo_i (
    .clk        (clk),
    .rstN       (rstN),
    .ticketIn   (ctrlInTicket),
    .pushValid  (ctrlInSrcRdy),
    .pop        (pop),
    .pushReady  (ctrlInDstRdy),
    .headTicket (headTicket),
    .headValid  (headValid)
  );

  frameRouter #(
    .outputCount(outputCount)
  ) frameRouter_i (
    .clk          (clk),
    .rstN         (rstN),
    .rxData       (rxData),
    .rxDrem       (rxDrem),
    .rxSof        (rxSof),
    .rxEof        (rxEof),
    .rxSrcRdy     (rxSrcRdy),
    .rxDstRdy     (rxDstRdy),
    .headTicket   (headTicket),
    .headValid    (headValid),
    .pop          (pop),
    .laneData     (laneData),
    .laneDrem     (laneDrem),
    .laneSof      (laneSof),
    .laneEof      (laneEof),
    .laneWrite    (laneWrite),
    .laneTagWrite (laneTagWrite),
    .laneTag      (laneTag),
    .laneFree     (laneFree),
    .laneTagFree  (laneTagFree)
  );

  for (genvar i = 0; i < outputCount; i++) begin : gLane
    flOutPort flOutPort_i (
      .clk           (clk),
      .rstN          (rstN),
      .laneData      (laneData),
      .laneDrem      (laneDrem),
      .laneSof       (laneSof),
      .laneEof       (laneEof),
      .laneWrite     (laneWrite[i]),
      .laneTag       (laneTag),
      .laneTagWrite  (laneTagWrite[i]),
      .txDstRdy      (txDstRdy[i]),
      .ctrlOutDstRdy (ctrlOutDstRdy[i]),
      .laneFree      (laneFree[i]),
      .laneTagFree   (laneTagFree[i]),
      .txData        (txData[i]),
      .txDrem        (txDrem[i]),
      .txSof         (txSof[i]),
      .txEof         (txEof[i]),
      .txSrcRdy      (txSrcRdy[i]),
      .ctrlOutTag    (ctrlOutTag[i]),
      .ctrlOutSrcRdy (ctrlOutSrcRdy[i])
    );
  end

endmodule : flTicketSplitter

// File: hdl/flOutPort.sv
// one TX lane with a two word buffer and two tag slots; writers must respect laneFree and laneTagFree
`timescale 1ns/1ps

module flOutPort import flTicketPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [dataWidth-1:0] laneData,
  input  logic [dremWidth-1:0] laneDrem,
  input  logic                 laneSof,
  input  logic                 laneEof,
  input  logic                 laneWrite,
  input  logic [tagWidth-1:0]  laneTag,
  input  logic                 laneTagWrite,
  input  logic                 txDstRdy,
  input  logic                 ctrlOutDstRdy,
  output logic                 laneFree,
  output logic                 laneTagFree,
  output logic [dataWidth-1:0] txData,
  output logic [dremWidth-1:0] txDrem,
  output logic                 txSof,
  output logic                 txEof,
  output logic                 txSrcRdy,
  output logic [tagWidth-1:0]  ctrlOutTag,
  output logic                 ctrlOutSrcRdy
);

  localparam int wordBits = dataWidth + dremWidth + 2;  // data, drem, sof and eof together

  logic [wordBits-1:0] inWord;     // incoming word packed for storage
  logic [wordBits-1:0] headWord;   // output register, drives the TX port directly
  logic [wordBits-1:0] spareWord;  // second entry, filled while the head is stalled
  logic [1:0]          wordCount;  // words held, 0 to 2
  logic                txFire;     // TX transfer this cycle
  logic [tagWidth-1:0] tagMem [2]; // two tag slots
  logic                tagWrPtr;
  logic                tagRdPtr;
  logic [1:0]          tagCount;   // tags held, 0 to 2
  logic                tagFire;    // ctrlOut transfer this cycle

  assign inWord = {laneData, laneDrem, laneSof, laneEof};
  assign {txData, txDrem, txSof, txEof} = headWord;
  assign txSrcRdy = (wordCount != 2'd0);  // low after reset since the buffer is empty
  assign laneFree = (wordCount != 2'd2);
  assign txFire   = txSrcRdy & txDstRdy;

  always_ff @(posedge clk) begin
    if (laneWrite && (wordCount == 2'd0 || (wordCount == 2'd1 && txFire))) begin
      headWord <= inWord;     // empty or draining head, new word goes straight out
    end else if (txFire && wordCount == 2'd2) begin
      headWord <= spareWord;  // spare moves up when the head leaves
    end
    if (laneWrite && wordCount == 2'd1 && !txFire) begin
      spareWord <= inWord;    // head stalled, park the word behind it
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordCount <= '0;
    end else begin
      wordCount <= wordCount + {1'b0, laneWrite} - {1'b0, txFire};
    end
  end

  assign ctrlOutSrcRdy = (tagCount != 2'd0);
  assign laneTagFree   = (tagCount != 2'd2);
  assign ctrlOutTag    = tagMem[tagRdPtr];  // oldest tag, kept in frame order
  assign tagFire       = ctrlOutSrcRdy & ctrlOutDstRdy;

  always_ff @(posedge clk) begin
    if (laneTagWrite) begin
      tagMem[tagWrPtr] <= laneTag;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tagWrPtr <= 1'b0;
      tagRdPtr <= 1'b0;
      tagCount <= '0;
    end else begin
      tagWrPtr <= tagWrPtr ^ laneTagWrite;  // two slots, the pointer just toggles
      tagRdPtr <= tagRdPtr ^ tagFire;
      tagCount <= tagCount + {1'b0, laneTagWrite} - {1'b0, tagFire};
    end
  end

  // the router must hold a word while this lane is full
  wordNotFull: assert property (@(posedge clk) disable iff (!rstN) laneWrite |-> laneFree)
    else $error("word written into a full lane");

  // same for the tag queue, which only fills on sof words
  tagNotFull: assert property (@(posedge clk) disable iff (!rstN)
    laneTagWrite |-> (laneTagFree && laneWrite && laneSof))
    else $error("tag written into a full lane or without its sof word");

endmodule : flOutPort

// File: hdl/frameRouter.sv
// forks each RX word to the lanes of the head ticket; rx data must stay stable while rxSrcRdy
`timescale 1ns/1ps

module frameRouter import flTicketPkg::*; #(
  parameter int outputCount = maxOutputs  // lanes in use, 1 to maxOutputs
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [dataWidth-1:0]   rxData,
  input  logic [dremWidth-1:0]   rxDrem,
  input  logic                   rxSof,
  input  logic                   rxEof,
  input  logic                   rxSrcRdy,
  output logic                   rxDstRdy,
  input  ticketT                 headTicket,
  input  logic                   headValid,
  output logic                   pop,
  output logic [dataWidth-1:0]   laneData,
  output logic [dremWidth-1:0]   laneDrem,
  output logic                   laneSof,
  output logic                   laneEof,
  output logic [outputCount-1:0] laneWrite,
  output logic [outputCount-1:0] laneTagWrite,
  output logic [tagWidth-1:0]    laneTag,
  input  logic [outputCount-1:0] laneFree,
  input  logic [outputCount-1:0] laneTagFree
);

  logic [outputCount-1:0] selMask;   // lanes that get the current frame
  logic [outputCount-1:0] done;      // selected lanes that already hold the current word
  logic [outputCount-1:0] laneOk;    // lane can take a word now, tag room included on sof
  logic [outputCount-1:0] canWrite;  // lanes that would take the word if it is offered
  logic                   inFrame;   // sof accepted and eof not yet accepted
  logic                   accept;    // rx word consumed this cycle

  // mask bits above outputCount address lanes that do not exist and are ignored
  assign selMask = headTicket.fields.mask[outputCount-1:0];

  // the sof word also needs a slot for the tag in that lane
  assign laneOk   = laneFree & (rxSof ? laneTagFree : {outputCount{1'b1}});
  assign canWrite = selMask & ~done & laneOk;

  // every lane writes on its own as soon as it is free, others may still be stalled
  assign laneWrite    = canWrite & {outputCount{rxSrcRdy & headValid}};
  assign laneTagWrite = laneWrite & {outputCount{rxSof}};  // tag goes with the first word only

  // word is taken once no selected lane is left waiting, an empty mask passes at once
  // and rxDstRdy never depends on rxSrcRdy
  assign rxDstRdy = headValid & (&(done | canWrite | ~selMask));
  assign accept   = rxSrcRdy & rxDstRdy;
  assign pop      = accept & rxEof;  // the ticket belongs to this frame until its eof leaves

  // all lanes share one word bus, laneWrite picks who stores it
  assign laneData = rxData;
  assign laneDrem = rxDrem;
  assign laneSof  = rxSof;
  assign laneEof  = rxEof;
  assign laneTag  = headTicket.fields.tag;  // mask is stripped, only the tag travels on

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      done    <= '0;
      inFrame <= 1'b0;
    end else begin
      if (accept) begin
        done    <= '0;       // next word starts with no lane served
        inFrame <= ~rxEof;   // single word frames never open a frame
      end else begin
        done <= done | laneWrite;  // remember lanes that took the held word
      end
    end
  end

  // a new frame may only start after the previous eof has gone through
  sofOutsideFrame: assert property (@(posedge clk) disable iff (!rstN)
    (rxSrcRdy && rxSof) |-> !inFrame)
    else $error("rxSof seen inside a frame");

  // a ticket is released only by the end of a frame that actually started
  popEndsFrame: assert property (@(posedge clk) disable iff (!rstN)
    pop |-> (inFrame || rxSof))
    else $error("ticket popped without a started frame");

  // lane activity never leaks outside the head mask, and nothing is marked done without a ticket
  writeInMask: assert property (@(posedge clk) disable iff (!rstN)
    (headValid ? ((done | laneWrite) & ~selMask) : done) == '0)
    else $error("lane written outside the selected mask");

endmodule : frameRouter

// File: hdl/ticketFifo.sv
// in-order ticket buffer; pop is only legal while headValid, pushReady stays low during reset
`timescale 1ns/1ps

module ticketFifo import flTicketPkg::*; #(
  parameter int depth = 4  // tickets that may be queued ahead of their frames
) (
  input  logic   clk,
  input  logic   rstN,
  input  ticketT ticketIn,
  input  logic   pushValid,
  input  logic   pop,
  output logic   pushReady,
  output ticketT headTicket,
  output logic   headValid
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  logic [ticketWidth-1:0] mem [depth];  // ticket storage indexed by the pointers
  logic [ptrWidth-1:0]    wrPtr;        // next slot to fill
  logic [ptrWidth-1:0]    rdPtr;        // slot presented on headTicket
  logic [cntWidth-1:0]    count;        // tickets currently held
  logic                   awake;        // goes high one cycle after reset is released
  logic                   push;         // ticket taken from ctrlIn this cycle

  assign headValid      = (count != '0);  // a ticket is waiting for its frame
  assign headTicket.raw = mem[rdPtr];     // head is read straight from storage
  // room exists unless full or a pop frees the slot in the same cycle
  assign pushReady      = awake & ((count != cntWidth'(depth)) | pop);
  assign push           = pushValid & pushReady;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= ticketIn.raw;  // the flat word is stored as is and decoded downstream
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      awake <= 1'b0;
    end else begin
      awake <= 1'b1;  // keeps ctrlInDstRdy low until the first cycle out of reset
      if (push) begin
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;  // wrap for any depth
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // count holds on idle cycles and on push with pop
      endcase
    end
  end

  // the router must only end a frame while a ticket is present
  popNeedsTicket: assert property (@(posedge clk) disable iff (!rstN) pop |-> headValid)
    else $error("ticket popped from an empty FIFO");

  // pointer and count bookkeeping never overruns storage
  countInRange: assert property (@(posedge clk) disable iff (!rstN) count <= cntWidth'(depth))
    else $error("ticket FIFO count above depth");

endmodule : ticketFifo

// File: hdl/flTicketPkg.sv
// shared FrameLink and ticket widths; ticket layout assumes maxOutputs mask bits above the tag
package flTicketPkg;

  localparam int dataWidth  = 32;  // FrameLink data word width
  localparam int dremWidth  = 2;   // byte remainder of the last word, 0 means all four bytes valid
  localparam int maxOutputs = 4;   // top level may use fewer lanes, never more
  localparam int tagWidth   = 12;  // tag forwarded to every selected ctrlOut

  // one mask bit per possible output sits above the tag, 16 bits in total
  localparam int ticketWidth = maxOutputs + tagWidth;

  // the same ticket word is stored as a flat vector and decoded as mask and tag
  typedef union packed {
    logic [ticketWidth-1:0] raw;  // whole word as seen by the ticket FIFO storage
    struct packed {
      logic [maxOutputs-1:0] mask;  // bit n set sends the frame to output n
      logic [tagWidth-1:0]   tag;   // copied unchanged to each delivered ctrlOut
    } fields;
  } ticketT;

endpackage : flTicketPkg
